//--- build.f
rv_pkg.sv
front_end.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
mem_stage.sv
rv_core.sv
tb_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - front_end.sv
  - decode_stage.sv
  - reg_file.sv
  - execute_stage.sv
  - mem_stage.sv
  - rv_core.sv
  - target: test
    files:
      - tb_core.sv

//--- tb_core.sv
/*
 * tb_core
 * Directed testbench for rv_core. It serves instructions from a program array,
 * answers the Wishbone bus from a word memory and checks retires against an ISA model.
 */
`timescale 1ns/1ns

module tb_core;
  import rv_pkg::*;

  localparam int reset_cycles = 10;

  logic      clock;
  logic      reset;
  addr_t     inst_addr;
  inst_t     inst;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  addr_t     wb_adr;
  word_t     wb_dat_w;
  word_t     wb_dat_r;
  logic      wb_ack;
  logic      commit_valid;
  addr_t     commit_pc;
  inst_t     commit_inst;
  logic      commit_write;
  reg_addr_t commit_rd;
  word_t     commit_data;

  inst_t prog [64];
  int    prog_len;
  word_t dmem [256];

  // expected retire stream and bus writes
  addr_t exp_pc [64];
  logic  exp_write [64];
  word_t exp_data [64];
  addr_t store_adr [$];
  word_t store_dat [$];

  logic [31:0] lfsr;
  logic        random_ack;
  logic        ack_busy;
  logic [1:0]  ack_wait;

  rv_core dut_i (.*);

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // program past its end reads as addi x0, x0, 0
  always_comb begin
    if (inst_addr[31:2] < prog_len) begin
      inst = prog[inst_addr[7:2]];
    end else begin
      inst = 32'h0000_0013;
    end
  end

  function automatic inst_t alu_rr(int funct7, int funct3, int rd, int rs1, int rs2);
    return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic inst_t alu_ri(int funct3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic inst_t lui_op(int rd, int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic inst_t lw_op(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic inst_t sw_op(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // memory contents before any store, spread over the full address
  function automatic word_t fill_word(addr_t a);
    return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [1:0] draw_delay();
    logic [1:0] d;
    d = '0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_next(lfsr);
      d = {d[0], lfsr[0]};
    end
    return d;
  endfunction

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic compare(string name, logic [31:0] got, logic [31:0] want);
    if (got !== want) begin
      stop_with_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  task automatic emit(inst_t i);
    prog[prog_len] = i;
    prog_len++;
  endtask

  // in-order ISA model of the subset
  task automatic predict();
    word_t regs [32];
    word_t mem [256];
    inst_t ins;
    word_t a;
    word_t b;
    word_t imm_i;
    word_t imm_s;
    word_t res;
    addr_t ea;
    logic  ok;
    logic  wr;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(i * 4);
    end
    store_adr.delete();
    store_dat.delete();
    for (int i = 0; i < prog_len; i++) begin
      ins   = prog[i];
      a     = regs[ins[19:15]];
      b     = regs[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      ok    = 1'b1;
      wr    = 1'b1;
      res   = '0;
      case (ins[6:0])
        7'b0110011: begin
          case (ins[14:12])
            3'b000:  res = ins[30] ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = a >> b[4:0];
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: ok = 1'b0;
          endcase
        end
        7'b0010011: begin
          case (ins[14:12])
            3'b000:  res = a + imm_i;
            3'b010:  res = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ imm_i;
            3'b110:  res = a | imm_i;
            3'b111:  res = a & imm_i;
            default: ok = 1'b0;
          endcase
        end
        7'b0110111: res = {ins[31:12], 12'b0};
        7'b0000011: begin
          ok = (ins[14:12] == 3'b010);
          ea = a + imm_i;
          res = mem[ea[9:2]];
        end
        7'b0100011: begin
          ok = (ins[14:12] == 3'b010);
          wr = 1'b0;
          ea = a + imm_s;
          if (ok) begin
            mem[ea[9:2]] = b;
            store_adr.push_back({ea[31:2], 2'b00});
            store_dat.push_back(b);
          end
        end
        default: ok = 1'b0;
      endcase
      wr = ok && wr && (ins[11:7] != 5'd0);
      if (wr) begin
        regs[ins[11:7]] = res;
      end
      exp_pc[i]    = reset_pc + 4 * i;
      exp_write[i] = wr;
      exp_data[i]  = res;
    end
  endtask

  task automatic start_test();
    @(posedge clock);
    reset <= 1'b1;
    @(posedge clock);
    prog_len = 0;
  endtask

  task automatic check_commit(int idx);
    compare("commit_pc", commit_pc, exp_pc[idx]);
    compare("commit_inst", commit_inst, prog[idx]);
    compare("commit_write", 32'(commit_write), 32'(exp_write[idx]));
    if (exp_write[idx]) begin
      compare("commit_rd", 32'(commit_rd), 32'(prog[idx][11:7]));
      compare("commit_data", commit_data, exp_data[idx]);
    end
  endtask

  task automatic run_program(string name);
    int cycles;
    int limit;
    int retired;
    int mem_ops;
    mem_ops = 0;
    for (int i = 0; i < prog_len; i++) begin
      if (prog[i][6:0] == 7'b0000011 || prog[i][6:0] == 7'b0100011) begin
        mem_ops++;
      end
    end
    // worst case per access is one setup cycle, three waits and the ack
    limit = 10 * prog_len + 5 * mem_ops;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = fill_word(i * 4);
    end
    predict();
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
    cycles  = 0;
    retired = 0;
    while (retired < prog_len) begin
      @(negedge clock);
      cycles++;
      if (cycles > limit) begin
        stop_with_failure($sformatf("timeout in %s: %0d of %0d instructions retired in %0d cycles",
                                    name, retired, prog_len, cycles));
      end
      if (commit_valid) begin
        check_commit(retired);
        retired++;
      end
    end
    if (store_adr.size() != 0) begin
      stop_with_failure($sformatf("%s: %0d expected stores never reached the data bus",
                                  name, store_adr.size()));
    end
  endtask

  // data memory slave, ack after a setup cycle plus a drawn wait
  always @(posedge clock) begin
    if (reset) begin
      wb_ack   <= 1'b0;
      ack_busy <= 1'b0;
      ack_wait <= '0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!ack_busy) begin
        ack_busy <= 1'b1;
        ack_wait <= random_ack ? draw_delay() : 2'd0;
      end else if (ack_wait != 2'd0) begin
        ack_wait <= ack_wait - 2'd1;
      end else begin
        ack_busy <= 1'b0;
        wb_ack   <= 1'b1;
        if (wb_we) begin
          dmem[wb_adr[9:2]] <= wb_dat_w;
        end else begin
          wb_dat_r <= dmem[wb_adr[9:2]];
        end
      end
    end
  end

  always @(negedge clock) begin
    if (!reset && wb_cyc && wb_stb && wb_we && wb_ack) begin
      if (store_adr.size() == 0) begin
        stop_with_failure("a store appeared on the data bus that the program does not contain");
      end else begin
        compare("wb_adr", wb_adr, store_adr.pop_front());
        compare("wb_dat_w", wb_dat_w, store_dat.pop_front());
      end
    end
  end

  task automatic alu_ops_test();
    start_test();
    emit(lui_op(1, 'h87654));
    emit(alu_ri(0, 2, 0, -13));
    emit(alu_ri(0, 3, 0, 'h5a5));
    emit(alu_ri(0, 4, 0, 7));
    emit(alu_ri(0, 21, 0, 33));
    emit(alu_rr('h00, 0, 5, 1, 2));
    emit(alu_rr('h20, 0, 6, 1, 3));
    emit(alu_rr('h00, 7, 7, 2, 3));
    emit(alu_rr('h00, 6, 8, 1, 3));
    emit(alu_rr('h00, 4, 9, 2, 3));
    emit(alu_rr('h00, 2, 10, 2, 3));
    emit(alu_rr('h00, 2, 11, 3, 2));
    emit(alu_rr('h00, 1, 12, 3, 4));
    emit(alu_rr('h00, 5, 13, 1, 4));
    // shift by 33 only uses the low five bits
    emit(alu_rr('h00, 1, 22, 3, 21));
    emit(alu_ri(0, 14, 1, 'h123));
    emit(alu_ri(7, 15, 2, 'h0f0));
    emit(alu_ri(6, 16, 3, -256));
    emit(alu_ri(4, 17, 1, 'h7ff));
    emit(alu_ri(2, 18, 2, -12));
    emit(alu_ri(2, 19, 3, 5));
    emit(lui_op(20, 'hfffff));
    run_program("alu ops");
  endtask

  task automatic forwarding_test();
    start_test();
    emit(alu_ri(0, 1, 0, 5));
    emit(alu_ri(0, 2, 1, 3));
    emit(alu_rr('h00, 0, 3, 1, 2));
    emit(alu_rr('h20, 0, 4, 3, 1));
    emit(alu_rr('h00, 4, 5, 4, 3));
    emit(alu_rr('h00, 1, 6, 5, 1));
    emit(alu_rr('h00, 6, 7, 6, 6));
    emit(alu_rr('h00, 7, 8, 7, 2));
    emit(alu_ri(0, 8, 8, 1));
    emit(alu_rr('h00, 0, 9, 8, 8));
    // distance three goes through the register file bypass
    emit(alu_ri(0, 10, 0, 9));
    emit(alu_ri(0, 0, 0, 0));
    emit(alu_ri(0, 0, 0, 0));
    emit(alu_rr('h00, 0, 11, 10, 10));
    run_program("forwarding");
  endtask

  task automatic load_store_test();
    start_test();
    emit(alu_ri(0, 1, 0, 'h100));
    emit(lui_op(2, 'hcafe1));
    emit(alu_ri(0, 2, 2, 'h234));
    emit(sw_op(2, 1, 8));
    emit(lw_op(3, 1, 8));
    emit(alu_rr('h00, 0, 4, 3, 3));
    emit(lw_op(5, 1, 12));
    emit(sw_op(5, 1, -4));
    emit(lw_op(6, 1, -4));
    emit(alu_ri(0, 7, 6, 1));
    run_program("store then load");
  endtask

  task automatic back_pressure_test();
    start_test();
    random_ack = 1'b1;
    emit(alu_ri(0, 1, 0, 'h200));
    emit(alu_ri(0, 2, 0, 1));
    for (int k = 0; k < 6; k++) begin
      emit(sw_op(2, 1, 4 * k));
      emit(lw_op(3, 1, 4 * k));
      emit(alu_rr('h00, 0, 2, 3, 2));
      emit(lw_op(4, 1, 4 * k + 64));
      emit(alu_rr('h00, 4, 5, 4, 2));
    end
    emit(sw_op(5, 1, 128));
    run_program("back-pressure");
    random_ack = 1'b0;
  endtask

  task automatic x0_and_bubble_test();
    start_test();
    emit(alu_ri(0, 0, 0, 55));
    emit(alu_ri(0, 1, 0, 9));
    emit(alu_rr('h00, 0, 0, 1, 1));
    emit(lui_op(0, 'h12345));
    // sltu, jal, lb and an all-ones word are outside the subset
    emit(alu_rr('h00, 3, 6, 1, 1));
    emit(32'h0040_02ef);
    emit({12'd0, 5'd0, 3'b000, 5'd7, 7'b0000011});
    emit(32'hffff_ffff);
    emit(alu_rr('h00, 0, 2, 0, 1));
    emit(alu_rr('h00, 6, 3, 0, 0));
    emit(alu_rr('h00, 0, 8, 5, 6));
    emit(alu_rr('h00, 0, 9, 7, 1));
    emit(sw_op(0, 0, 64));
    emit(lw_op(4, 0, 64));
    emit(alu_ri(0, 10, 4, 1));
    run_program("x0 and bubbles");
  endtask

  initial begin
    reset      = 1'b1;
    wb_ack     = 1'b0;
    wb_dat_r   = '0;
    lfsr       = 32'h2c29ac2b;
    random_ack = 1'b0;
    ack_busy   = 1'b0;
    ack_wait   = '0;
    prog_len   = 0;
    alu_ops_test();
    forwarding_test();
    load_store_test();
    back_pressure_test();
    x0_and_bubble_test();
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- rv_core.sv
/*
 * rv_core
 * Five-stage in-order RV32I subset core with a combinational fetch port,
 * a Wishbone classic data master and a retire port.
 */
`timescale 1ns/1ns

module rv_core (
  input  logic              clock,
  input  logic              reset,
  output rv_pkg::addr_t     inst_addr,
  input  rv_pkg::inst_t     inst,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output rv_pkg::addr_t     wb_adr,
  output rv_pkg::word_t     wb_dat_w,
  input  rv_pkg::word_t     wb_dat_r,
  input  logic              wb_ack,
  output logic              commit_valid,
  output rv_pkg::addr_t     commit_pc,
  output rv_pkg::inst_t     commit_inst,
  output logic              commit_write,
  output rv_pkg::reg_addr_t commit_rd,
  output rv_pkg::word_t     commit_data
);
  import rv_pkg::*;

  // fetch and decode
  logic      id_valid, load_stall, decode_allowin;
  addr_t     id_pc;
  reg_addr_t rs1, rs2;
  word_t     rf_data1, rf_data2;

  // decode to execute
  logic      ex_valid, ex_allowin, ex_use_imm, ex_reg_write, ex_load, ex_store;
  addr_t     ex_pc;
  inst_t     ex_inst;
  alu_op_e   ex_alu_op;
  word_t     ex_imm, ex_op1, ex_op2;
  reg_addr_t ex_rs1, ex_rs2, ex_rd;

  // execute to memory
  logic      mem_valid, mem_allowin, mem_reg_write, mem_load, mem_store;
  addr_t     mem_pc;
  inst_t     mem_inst;
  word_t     mem_result, mem_store_data;
  reg_addr_t mem_rd;

  // forwarding and register write
  logic      mem_fwd_valid, wb_fwd_valid, rf_wen;
  reg_addr_t mem_fwd_rd, wb_fwd_rd, rf_waddr;
  word_t     mem_fwd_data, wb_fwd_data, rf_wdata;

  front_end front_end_i (.*);

  decode_stage decode_stage_i (.*);

  reg_file reg_file_i (
    .clock  (clock),
    .reset  (reset),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata),
    .wen    (rf_wen),
    .rdata1 (rf_data1),
    .rdata2 (rf_data2)
  );

  execute_stage execute_stage_i (.*);

  mem_stage mem_stage_i (.*);

endmodule

//--- mem_stage.sv
/*
 * mem_stage
 * Wishbone classic data access, MEM/WB register, writeback select and
 * the retire port.
 */
`timescale 1ns/1ns

module mem_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              mem_valid,
  input  rv_pkg::addr_t     mem_pc,
  input  rv_pkg::inst_t     mem_inst,
  input  rv_pkg::word_t     mem_result,
  input  rv_pkg::word_t     mem_store_data,
  input  rv_pkg::reg_addr_t mem_rd,
  input  logic              mem_reg_write,
  input  logic              mem_load,
  input  logic              mem_store,
  input  rv_pkg::word_t     wb_dat_r,
  input  logic              wb_ack,
  output logic              mem_allowin,
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output rv_pkg::addr_t     wb_adr,
  output rv_pkg::word_t     wb_dat_w,
  output logic              mem_fwd_valid,
  output rv_pkg::reg_addr_t mem_fwd_rd,
  output rv_pkg::word_t     mem_fwd_data,
  output logic              wb_fwd_valid,
  output rv_pkg::reg_addr_t wb_fwd_rd,
  output rv_pkg::word_t     wb_fwd_data,
  output rv_pkg::reg_addr_t rf_waddr,
  output rv_pkg::word_t     rf_wdata,
  output logic              rf_wen,
  output logic              commit_valid,
  output rv_pkg::addr_t     commit_pc,
  output rv_pkg::inst_t     commit_inst,
  output logic              commit_write,
  output rv_pkg::reg_addr_t commit_rd,
  output rv_pkg::word_t     commit_data
);
  import rv_pkg::*;

  logic      ready_go;
  logic      mem_done;
  logic      wb_valid;
  logic      wb_write;
  addr_t     wb_pc;
  inst_t     wb_inst;
  reg_addr_t wb_rd;
  word_t     wb_data;

  // bus cycle open for as long as a load or store sits here
  assign wb_cyc   = mem_valid && (mem_load || mem_store);
  assign wb_stb   = wb_cyc;
  assign wb_we    = wb_cyc && mem_store;
  assign wb_adr   = {mem_result[31:2], 2'b00};
  assign wb_dat_w = mem_store_data;

  assign ready_go    = !wb_cyc || wb_ack;
  assign mem_done    = mem_valid && ready_go;
  assign mem_allowin = !mem_valid || ready_go;

  // a load forwards its read data only once ack arrives
  assign mem_fwd_valid = mem_reg_write && (!mem_load || wb_ack);
  assign mem_fwd_rd    = mem_rd;
  assign mem_fwd_data  = mem_load ? wb_dat_r : mem_result;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
      wb_write <= 1'b0;
    end else begin
      wb_valid <= mem_done;
      wb_write <= mem_done && mem_reg_write && (mem_rd != '0);
    end
  end

  always_ff @(posedge clock) begin
    if (mem_done) begin
      wb_pc   <= mem_pc;
      wb_inst <= mem_inst;
      wb_rd   <= mem_rd;
      wb_data <= mem_load ? wb_dat_r : mem_result;
    end
  end

  assign rf_waddr = wb_rd;
  assign rf_wdata = wb_data;
  assign rf_wen   = wb_write;

  assign wb_fwd_valid = wb_write;
  assign wb_fwd_rd    = wb_rd;
  assign wb_fwd_data  = wb_data;

  assign commit_valid = wb_valid;
  assign commit_pc    = wb_pc;
  assign commit_inst  = wb_inst;
  assign commit_write = wb_write;
  assign commit_rd    = wb_rd;
  assign commit_data  = wb_data;

  // held stage must keep the request steady until the slave acks
  a_bus_hold: assert property (@(posedge clock) disable iff (reset)
    (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr) && $stable(wb_we) &&
                             $stable(wb_dat_w)));

endmodule

//--- execute_stage.sv
/*
 * execute_stage
 * Operand forwarding, ALU and the EX/MEM register.
 */
`timescale 1ns/1ns

module execute_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              ex_valid,
  input  rv_pkg::addr_t     ex_pc,
  input  rv_pkg::inst_t     ex_inst,
  input  rv_pkg::alu_op_e   ex_alu_op,
  input  logic              ex_use_imm,
  input  rv_pkg::word_t     ex_imm,
  input  rv_pkg::word_t     ex_op1,
  input  rv_pkg::word_t     ex_op2,
  input  rv_pkg::reg_addr_t ex_rs1,
  input  rv_pkg::reg_addr_t ex_rs2,
  input  rv_pkg::reg_addr_t ex_rd,
  input  logic              ex_reg_write,
  input  logic              ex_load,
  input  logic              ex_store,
  input  logic              mem_allowin,
  input  logic              mem_fwd_valid,
  input  rv_pkg::reg_addr_t mem_fwd_rd,
  input  rv_pkg::word_t     mem_fwd_data,
  input  logic              wb_fwd_valid,
  input  rv_pkg::reg_addr_t wb_fwd_rd,
  input  rv_pkg::word_t     wb_fwd_data,
  output logic              ex_allowin,
  output logic              mem_valid,
  output rv_pkg::addr_t     mem_pc,
  output rv_pkg::inst_t     mem_inst,
  output rv_pkg::word_t     mem_result,
  output rv_pkg::word_t     mem_store_data,
  output rv_pkg::reg_addr_t mem_rd,
  output logic              mem_reg_write,
  output logic              mem_load,
  output logic              mem_store
);
  import rv_pkg::*;

  word_t src1;
  word_t src2;
  word_t src1_q;
  word_t src2_q;
  word_t alu_b;
  word_t alu_out;
  logic  src_held;

  // newest producer wins
  function automatic word_t pick(reg_addr_t rs, word_t base);
    if (rs != '0 && mem_fwd_valid && mem_fwd_rd == rs) begin
      return mem_fwd_data;
    end
    if (rs != '0 && wb_fwd_valid && wb_fwd_rd == rs) begin
      return wb_fwd_data;
    end
    return base;
  endfunction

  // while stalled, writeback drains, so keep the operands seen last cycle
  always_comb begin
    src1  = pick(ex_rs1, src_held ? src1_q : ex_op1);
    src2  = pick(ex_rs2, src_held ? src2_q : ex_op2);
    alu_b = ex_use_imm ? ex_imm : src2;
    case (ex_alu_op)
      alu_add:    alu_out = src1 + alu_b;
      alu_sub:    alu_out = src1 - alu_b;
      alu_and:    alu_out = src1 & alu_b;
      alu_or:     alu_out = src1 | alu_b;
      alu_xor:    alu_out = src1 ^ alu_b;
      alu_slt:    alu_out = {31'b0, $signed(src1) < $signed(alu_b)};
      alu_sll:    alu_out = src1 << alu_b[4:0];
      alu_srl:    alu_out = src1 >> alu_b[4:0];
      alu_pass_b: alu_out = alu_b;
      default:    alu_out = '0;
    endcase
  end

  assign ex_allowin = !ex_valid || mem_allowin;

  always_ff @(posedge clock) begin
    if (reset) begin
      src_held <= 1'b0;
    end else begin
      src_held <= ex_valid && !mem_allowin;
    end
  end

  always_ff @(posedge clock) begin
    src1_q <= src1;
    src2_q <= src2;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid     <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_load      <= 1'b0;
      mem_store     <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid     <= ex_valid;
      mem_reg_write <= ex_reg_write;
      mem_load      <= ex_load;
      mem_store     <= ex_store;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_allowin && ex_valid) begin
      mem_pc         <= ex_pc;
      mem_inst       <= ex_inst;
      mem_result     <= alu_out;
      mem_store_data <= src2;
      mem_rd         <= ex_rd;
    end
  end

endmodule

//--- reg_file.sv
/*
 * reg_file
 * 32 x 32 integer register file, two combinational reads and one write.
 * A write in flight is bypassed to the read ports.
 */
`timescale 1ns/1ns

module reg_file (
  input  logic              clock,
  input  logic              reset,
  input  rv_pkg::reg_addr_t raddr1,
  input  rv_pkg::reg_addr_t raddr2,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::word_t     wdata,
  input  logic              wen,
  output rv_pkg::word_t     rdata1,
  output rv_pkg::word_t     rdata2
);
  import rv_pkg::*;

  word_t regs [32];

  function automatic word_t read_port(reg_addr_t ra);
    if (ra == '0) begin
      return '0;
    end
    if (wen && (waddr == ra)) begin
      return wdata;
    end
    return regs[ra];
  endfunction

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

//--- decode_stage.sv
/*
 * decode_stage
 * Decodes the supported subset into ALU and memory controls, builds the
 * immediates and loads the ID/EX register. Unknown encodings retire as no-ops.
 */
`timescale 1ns/1ns

module decode_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              id_valid,
  input  rv_pkg::addr_t     id_pc,
  input  rv_pkg::inst_t     inst,
  input  logic              load_stall,
  input  logic              ex_allowin,
  input  rv_pkg::word_t     rf_data1,
  input  rv_pkg::word_t     rf_data2,
  output logic              decode_allowin,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output logic              ex_valid,
  output rv_pkg::addr_t     ex_pc,
  output rv_pkg::inst_t     ex_inst,
  output rv_pkg::alu_op_e   ex_alu_op,
  output logic              ex_use_imm,
  output rv_pkg::word_t     ex_imm,
  output rv_pkg::word_t     ex_op1,
  output rv_pkg::word_t     ex_op2,
  output rv_pkg::reg_addr_t ex_rs1,
  output rv_pkg::reg_addr_t ex_rs2,
  output rv_pkg::reg_addr_t ex_rd,
  output logic              ex_reg_write,
  output logic              ex_load,
  output logic              ex_store
);
  import rv_pkg::*;

  alu_op_e    alu_op;
  word_t      imm;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;
  logic [2:0] funct3;
  logic       dec_ok;
  logic       use_imm;
  logic       use_rs1;
  logic       use_rs2;
  logic       dec_write;
  logic       dec_load;
  logic       dec_store;
  logic       to_ex;

  assign funct3 = inst[14:12];
  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u  = {inst[31:12], 12'b0};

  always_comb begin
    alu_op    = alu_add;
    imm       = imm_i;
    dec_ok    = 1'b1;
    use_imm   = 1'b1;
    use_rs1   = 1'b1;
    use_rs2   = 1'b0;
    dec_write = 1'b1;
    dec_load  = 1'b0;
    dec_store = 1'b0;
    case (inst[6:0])
      op_reg: begin
        use_imm = 1'b0;
        use_rs2 = 1'b1;
        case (funct3)
          3'b000: begin
            if (inst[30]) begin
              alu_op = alu_sub;
            end else begin
              alu_op = alu_add;
            end
          end
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b100:  alu_op = alu_xor;
          3'b101:  alu_op = alu_srl;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: dec_ok = 1'b0;
        endcase
      end
      op_imm: begin
        case (funct3)
          3'b000:  alu_op = alu_add;
          3'b010:  alu_op = alu_slt;
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: dec_ok = 1'b0;
        endcase
      end
      op_lui: begin
        alu_op  = alu_pass_b;
        imm     = imm_u;
        use_rs1 = 1'b0;
      end
      op_load: begin
        dec_ok   = (funct3 == 3'b010);
        dec_load = 1'b1;
      end
      op_store: begin
        dec_ok    = (funct3 == 3'b010);
        imm       = imm_s;
        use_rs2   = 1'b1;
        dec_write = 1'b0;
        dec_store = 1'b1;
      end
      default: dec_ok = 1'b0;
    endcase
  end

  // unused sources read x0 so they never match a hazard or forward
  assign rs1 = (dec_ok && use_rs1) ? inst[19:15] : '0;
  assign rs2 = (dec_ok && use_rs2) ? inst[24:20] : '0;

  assign to_ex          = id_valid && !load_stall;
  assign decode_allowin = !id_valid || (!load_stall && ex_allowin);

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid     <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_load      <= 1'b0;
      ex_store     <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid     <= to_ex;
      ex_reg_write <= to_ex && dec_ok && dec_write;
      ex_load      <= to_ex && dec_ok && dec_load;
      ex_store     <= to_ex && dec_ok && dec_store;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_allowin && to_ex) begin
      ex_pc      <= id_pc;
      ex_inst    <= inst;
      ex_alu_op  <= alu_op;
      ex_use_imm <= use_imm;
      ex_imm     <= imm;
      ex_op1     <= rf_data1;
      ex_op2     <= rf_data2;
      ex_rs1     <= rs1;
      ex_rs2     <= rs2;
      ex_rd      <= inst[11:7];
    end
  end

  a_mem_flags: assert property (@(posedge clock) disable iff (reset)
    (ex_load || ex_store) |-> (ex_valid && !(ex_load && ex_store)));

endmodule

//--- front_end.sv
/*
 * front_end
 * Program counter and IF/ID valid bit, plus load-use stall detection.
 * The PC of the instruction in decode drives the fetch address.
 */
`timescale 1ns/1ns

module front_end (
  input  logic              clock,
  input  logic              reset,
  input  logic              decode_allowin,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  logic              ex_load,
  input  rv_pkg::reg_addr_t ex_rd,
  output rv_pkg::addr_t     inst_addr,
  output logic              id_valid,
  output rv_pkg::addr_t     id_pc,
  output logic              load_stall
);
  import rv_pkg::*;

  // load in execute feeding a source of the decode instruction
  assign load_stall = id_valid && ex_load && (ex_rd != '0) &&
                      ((rs1 == ex_rd) || (rs2 == ex_rd));

  assign inst_addr = id_pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
      id_pc    <= reset_pc;
    end else begin
      // first cycle out of reset fetches reset_pc itself
      id_valid <= 1'b1;
      if (id_valid && decode_allowin && !load_stall) begin
        id_pc <= id_pc + 32'd4;
      end
    end
  end

endmodule

//--- rv_pkg.sv
/*
 * rv_pkg
 * Shared widths, vector types, opcode and ALU encodings and the reset PC
 * for the five-stage RV32I subset core.
 */
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0]     addr_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;

  // first fetch after reset
  localparam addr_t reset_pc = 32'h0000_0000;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_reg   = 7'b0110011,
    op_imm   = 7'b0010011,
    op_lui   = 7'b0110111,
    op_load  = 7'b0000011,
    op_store = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_pass_b  // lui
  } alu_op_e;

endpackage
